// ==== src/pce_io_pkg.sv ====
`default_nettype none

package pce_io_pkg;

  // one pad, msb first
  // b6 b5 b4 b3 start select b2 b1 up down left right
  // a set bit means pressed
  typedef logic [11:0] pad_buttons_t;

  // active low, handed back to the core as joy_in
  typedef logic [3:0] pad_nibble_t;

  // host download stream, byte addressed words
  typedef logic [23:0] rom_addr_t;
  typedef logic [15:0] rom_word_t;

  // backup ram seen as 2K bytes by the core
  typedef logic [10:0] bram_byte_addr_t;
  // and as 1K words by the save path
  typedef logic [9:0] bram_word_addr_t;

  // header write after reset, then normal service
  typedef enum logic {
    init_header,
    init_done
  } bram_init_e;

  // address[23:4] blocks that hold the populous title string
  // one per header layout (with and without copier header)
  localparam logic [19:0] POP_SIG_BASE_A = 20'h212;
  localparam logic [19:0] POP_SIG_BASE_B = 20'h1f2;

  // "PO" "PU" "LO" "US"
  // expected at block offsets 6, 8, 10 and 12
  localparam rom_word_t POP_SIG_WORDS [4] = '{
    16'h4F50,
    16'h5550,
    16'h4F4C,
    16'h5355
  };

  // "HUBM" followed by 0x00881080, low byte first in each word
  localparam logic [15:0] BRAM_HEADER [4] = '{
    16'h5548,
    16'h4D42,
    16'h8800,
    16'h8010
  };

endpackage

`default_nettype wire

// ==== src/pad_multitap.sv ====
`timescale 1ns/1ns
`default_nettype none

module pad_multitap
  import pce_io_pkg::*;
#(
  parameter int NUM_PADS = 4
) (
  input wire clk_sys_42_95,
  input wire rst_n,
  input wire pad_buttons_t [NUM_PADS-1:0] pads,
  // joy_out[0], selects the nibble and clocks the tap
  input wire pad_sel,
  // joy_out[1], rewinds the tap to port 0
  input wire pad_clr,
  input wire multitap_en,
  input wire six_button_en,
  output pad_nibble_t pad_nibble
);

  // word the core reads from one pad, active low
  // [3:0] run/sel/II/I, [7:4] dpad, [11:8] III..VI, [15:12] zero
  function automatic logic [15:0] pad_word(pad_buttons_t b);
    logic [3:0] dpad;
    // left, down, right, up
    dpad = {b[1], b[2], b[0], b[3]};
    return {4'h0, ~b[11:8], ~dpad, ~b[7:4]};
  endfunction

  logic [15:0] port_word [8];
  logic [2:0] port_q;
  logic high_buttons;
  logic sel_q;
  logic clr_q;
  logic sel_rise;
  logic clr_rise;
  logic [1:0] nib_sel;

  // one word per tap port
  for (genvar p = 0; p < 8; p++) begin : g_port
    if (p < NUM_PADS) begin : g_pad
      assign port_word[p] = pad_word(pads[p]);
    end else if (p <= 4) begin : g_empty
      // unplugged pad reads as nothing pressed
      assign port_word[p] = pad_word('0);
    end else begin : g_beyond
      // ports the tap does not have
      assign port_word[p] = 16'h0FFF;
    end
  end

  assign sel_rise = pad_sel & ~sel_q;
  assign clr_rise = pad_clr & ~clr_q;

  // second pair of nibbles only in 6-button phase
  assign nib_sel = {high_buttons, pad_sel};

  always_ff @(posedge clk_sys_42_95 or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= 1'b0;
      clr_q <= 1'b0;
      port_q <= 3'd0;
      high_buttons <= 1'b0;
      pad_nibble <= '0;
    end else begin
      sel_q <= pad_sel;
      clr_q <= pad_clr;
      if (pad_clr) begin
        // clear held, the core sees all lines low
        port_q <= 3'd0;
        pad_nibble <= '0;
        // 6-button pads alternate between the two halves per clear
        if (clr_rise) begin
          high_buttons <= ~high_buttons & six_button_en;
        end
      end else begin
        pad_nibble <= port_word[port_q][{nib_sel, 2'b00} +: 4];
        // tap steps on each select edge, stops at the last port
        if (sel_rise && multitap_en && port_q != 3'd7) begin
          port_q <= port_q + 3'd1;
        end
      end
    end
  end

  // once the scan has run off the end it stays there until the next clear
  assert property (@(posedge clk_sys_42_95) disable iff (!rst_n)
    (port_q == 3'd7 && !pad_clr) |=> port_q == 3'd7)
    else $error("multitap port counter wrapped past port 7");

endmodule

`default_nettype wire

// ==== src/cart_loader.sv ====
`timescale 1ns/1ns
`default_nettype none

module cart_loader
  import pce_io_pkg::*;
(
  input wire clk_sys_42_95,
  input wire rst_n,
  input wire cart_download,
  input wire ioctl_wr,
  input wire rom_word_t ioctl_data,
  input wire swap_en,
  input wire rom_wr_ready,
  output logic ioctl_ready,
  output logic rom_wr_valid,
  output rom_addr_t rom_wr_addr,
  output rom_word_t rom_wr_data,
  output logic rom_header,
  output logic rom_populous,
  output logic [11:0] rom_size
);

  // bit order reversed in each byte, bytes exchanged
  // i.e. the whole word mirrored
  function automatic rom_word_t swap_word(rom_word_t d);
    rom_word_t r;
    for (int i = 0; i < 16; i++) begin
      r[i] = d[15 - i];
    end
    return r;
  endfunction

  logic dl_q;
  logic wr_q;
  logic dl_rise;
  logic wr_rise;
  logic wr_fall;
  logic capture;
  logic wr_done;
  rom_addr_t addr_q;
  rom_word_t word;
  // one flag per layout, indexed by address bit 13 on check
  logic [1:0] populous_q;
  logic sig_block;
  logic sig_hit;
  logic [1:0] sig_idx;
  logic sig_mismatch;

  assign dl_rise = cart_download & ~dl_q;
  assign wr_rise = ioctl_wr & ~wr_q;
  assign wr_fall = ~ioctl_wr & wr_q;

  // new download restart wins over a strobe in the same cycle
  assign capture = wr_rise & ~dl_rise;
  assign wr_done = rom_wr_valid & rom_wr_ready;

  assign word = swap_en ? swap_word(ioctl_data) : ioctl_data;

  // populous title check
  assign sig_block = (addr_q[23:4] == POP_SIG_BASE_A) ||
                     (addr_q[23:4] == POP_SIG_BASE_B);

  always_comb begin
    sig_hit = sig_block;
    sig_idx = 2'd0;
    case (addr_q[3:0])
      4'd6: sig_idx = 2'd0;
      4'd8: sig_idx = 2'd1;
      4'd10: sig_idx = 2'd2;
      4'd12: sig_idx = 2'd3;
      default: sig_hit = 1'b0;
    endcase
  end

  assign sig_mismatch = sig_hit && (word != POP_SIG_WORDS[sig_idx]);

  always_ff @(posedge clk_sys_42_95 or negedge rst_n) begin
    if (!rst_n) begin
      dl_q <= 1'b0;
      wr_q <= 1'b0;
      addr_q <= '0;
      populous_q <= 2'b11;
      rom_wr_valid <= 1'b0;
    end else begin
      dl_q <= cart_download;
      wr_q <= ioctl_wr;
      if (dl_rise) begin
        addr_q <= '0;
        populous_q <= 2'b11;
      end else if (capture) begin
        if (sig_mismatch) begin
          populous_q[addr_q[13]] <= 1'b0;
        end
      end else if (wr_fall) begin
        // next word once the host drops the strobe
        addr_q <= addr_q + 24'd2;
      end
      // single entry, host is held off while it is full
      if (capture) begin
        rom_wr_valid <= 1'b1;
      end else if (wr_done) begin
        rom_wr_valid <= 1'b0;
      end
    end
  end

  // address sampled before the falling-edge increment
  always_ff @(posedge clk_sys_42_95) begin
    if (capture) begin
      rom_wr_addr <= addr_q;
      rom_wr_data <= word;
    end
  end

  assign ioctl_ready = ~rom_wr_valid;

  // bit 9 set means the image starts with a 512-byte copier header
  assign rom_header = addr_q[9];
  assign rom_populous = populous_q[addr_q[9]];
  assign rom_size = addr_q[23:12];

  // memory controller may stall, the word must not move under it
  assert property (@(posedge clk_sys_42_95) disable iff (!rst_n)
    (rom_wr_valid && !rom_wr_ready) |=> ($stable(rom_wr_addr) && $stable(rom_wr_data)))
    else $error("rom write word changed while stalled");

  // host side of the back-pressure contract
  assert property (@(posedge clk_sys_42_95) disable iff (!rst_n)
    (ioctl_wr && !wr_q) |-> ioctl_ready)
    else $error("ioctl_wr raised while ioctl_ready was low");

endmodule

`default_nettype wire

// ==== src/backup_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module backup_ram
  import pce_io_pkg::*;
(
  input wire clk_sys_42_95,
  input wire rst_n,
  // core side, one byte per address
  input wire bram_byte_addr_t bram_addr,
  input wire [7:0] bram_wdata,
  input wire bram_we,
  // save side, one word per address
  input wire bram_word_addr_t save_addr,
  input wire [15:0] save_wdata,
  input wire save_we,
  output logic [7:0] bram_rdata,
  output logic [15:0] save_rdata
);

  // two bytes per word, even byte address in lane 0
  logic [1:0][7:0] mem [1024];

  bram_init_e state_q;
  logic [1:0] hdr_cnt;

  // save-side write path, shared with the header fill
  bram_word_addr_t wr_addr;
  logic [15:0] wr_data;
  logic wr_en;

  always_comb begin
    if (state_q == init_header) begin
      wr_addr = {8'd0, hdr_cnt};
      wr_data = BRAM_HEADER[hdr_cnt];
      wr_en = 1'b1;
    end else begin
      wr_addr = save_addr;
      wr_data = save_wdata;
      wr_en = save_we;
    end
  end

  // four header words, one per cycle after reset
  always_ff @(posedge clk_sys_42_95 or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= init_header;
      hdr_cnt <= 2'd0;
    end else if (state_q == init_header) begin
      hdr_cnt <= hdr_cnt + 2'd1;
      if (hdr_cnt == 2'd3) begin
        state_q <= init_done;
      end
    end
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (bram_we) begin
      mem[bram_addr[10:1]][bram_addr[0]] <= bram_wdata;
    end
    // same word from both sides in one cycle, save side lands last
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    // registered reads, old data on a colliding write
    bram_rdata <= mem[bram_addr[10:1]][bram_addr[0]];
    save_rdata <= mem[save_addr];
  end

  // header fill happens once per reset and is never re-entered
  assert property (@(posedge clk_sys_42_95) disable iff (!rst_n)
    (state_q == init_done) |=> (state_q == init_done))
    else $error("backup ram left init_done without a reset");

endmodule

`default_nettype wire

// ==== src/pce_io_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pce_io_top
  import pce_io_pkg::*;
#(
  // pads physically attached to the multitap, 1 to 5
  parameter int NUM_PADS = 4
) (
  input wire clk_sys_42_95,
  input wire rst_n,

  // pads and the core's joy_out lines
  input wire pad_buttons_t [NUM_PADS-1:0] pads,
  input wire pad_sel,
  input wire pad_clr,
  input wire multitap_en,
  input wire six_button_en,
  output wire pad_nibble_t pad_nibble,

  // host download
  input wire cart_download,
  input wire ioctl_wr,
  input wire rom_word_t ioctl_data,
  input wire swap_en,
  output wire ioctl_ready,

  // toward the memory controller
  output wire rom_wr_valid,
  input wire rom_wr_ready,
  output wire rom_addr_t rom_wr_addr,
  output wire rom_word_t rom_wr_data,

  // cart status for the core
  output wire rom_header,
  output wire rom_populous,
  output wire [11:0] rom_size,

  // backup ram, core side bytes
  input wire bram_byte_addr_t bram_addr,
  input wire [7:0] bram_wdata,
  input wire bram_we,
  output wire [7:0] bram_rdata,

  // backup ram, save side words
  input wire bram_word_addr_t save_addr,
  input wire [15:0] save_wdata,
  input wire save_we,
  output wire [15:0] save_rdata
);

  // joypad port, multitap and 6-button handling
  pad_multitap #(
    .NUM_PADS(NUM_PADS)
  ) u_pad_multitap (
    .clk_sys_42_95(clk_sys_42_95),
    .rst_n(rst_n),
    .pads(pads),
    .pad_sel(pad_sel),
    .pad_clr(pad_clr),
    .multitap_en(multitap_en),
    .six_button_en(six_button_en),
    .pad_nibble(pad_nibble)
  );

  // rom download into the memory controller
  cart_loader u_cart_loader (
    .clk_sys_42_95(clk_sys_42_95),
    .rst_n(rst_n),
    .cart_download(cart_download),
    .ioctl_wr(ioctl_wr),
    .ioctl_data(ioctl_data),
    .swap_en(swap_en),
    .rom_wr_ready(rom_wr_ready),
    .ioctl_ready(ioctl_ready),
    .rom_wr_valid(rom_wr_valid),
    .rom_wr_addr(rom_wr_addr),
    .rom_wr_data(rom_wr_data),
    .rom_header(rom_header),
    .rom_populous(rom_populous),
    .rom_size(rom_size)
  );

  // battery ram image
  backup_ram u_backup_ram (
    .clk_sys_42_95(clk_sys_42_95),
    .rst_n(rst_n),
    .bram_addr(bram_addr),
    .bram_wdata(bram_wdata),
    .bram_we(bram_we),
    .save_addr(save_addr),
    .save_wdata(save_wdata),
    .save_we(save_we),
    .bram_rdata(bram_rdata),
    .save_rdata(save_rdata)
  );

endmodule

`default_nettype wire

// ==== dv/pce_io_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module pce_io_checker
  import pce_io_pkg::*;
#(
  parameter int NUM_PADS = 4
) (
  input wire clk_sys_42_95,
  input wire rst_n,
  input wire pad_buttons_t [NUM_PADS-1:0] pads,
  input wire pad_nibble_t pad_nibble,
  input wire ioctl_ready,
  input wire rom_wr_valid,
  input wire rom_wr_ready,
  input wire rom_addr_t rom_wr_addr,
  input wire rom_word_t rom_wr_data,
  input wire rom_header,
  input wire rom_populous,
  input wire [11:0] rom_size,
  input wire [7:0] bram_rdata,
  input wire [15:0] save_rdata
);

  string test_name = "none";
  int test_errs = 0;
  int err_total = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  // host words in their expected (swapped) form
  rom_word_t exp_q [$];
  rom_addr_t next_addr = '0;
  // one populous flag per address bit 13
  logic [1:0] flags = 2'b11;

  function automatic logic [7:0] rev8(logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[7 - i] = b[i];
    end
    return r;
  endfunction

  // active-low word of one port
  // ports past the tap read as 0FFF
  function automatic logic [15:0] port_word(int port);
    pad_buttons_t b;
    if (port > 4) begin
      return 16'h0FFF;
    end
    b = (port < NUM_PADS) ? pads[port] : '0;
    // left, down, right, up in [7:4]
    return {4'h0, ~b[11:8], ~{b[1], b[2], b[0], b[3]}, ~b[7:4]};
  endfunction

  task automatic fail(string msg);
    $display("FAILED t=%0t [%s] %s", $time, test_name, msg);
    test_errs++;
    err_total++;
  endtask

  task automatic compare(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      fail($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic begin_test(string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("test %s: passed", test_name);
      pass_cnt++;
    end else begin
      $display("test %s: %0d errors", test_name, test_errs);
      fail_cnt++;
    end
  endtask

  // clr high forces a zero nibble
  task automatic check_pad(int port, logic [1:0] idx, logic clr);
    logic [15:0] w;
    w = port_word(port);
    compare($sformatf("nibble port %0d index %0d", port, idx), pad_nibble,
            clr ? 4'h0 : w[idx*4 +: 4]);
  endtask

  // core port byte one cycle after its address
  task automatic check_core_byte(bram_byte_addr_t a, logic [7:0] exp);
    compare($sformatf("core byte %h", a), bram_rdata, exp);
  endtask

  // save port word one cycle after its address
  task automatic check_save_word(bram_word_addr_t a, logic [15:0] exp);
    compare($sformatf("save word %h", a), save_rdata, exp);
  endtask

  task automatic start_download();
    exp_q.delete();
    next_addr = '0;
    flags = 2'b11;
  endtask

  // swapped form mirrors the bits of each byte and exchanges the bytes
  task automatic expect_word(rom_word_t w, logic swap);
    exp_q.push_back(swap ? {rev8(w[7:0]), rev8(w[15:8])} : w);
  endtask

  task automatic take_word();
    rom_word_t exp;
    int k;
    if (exp_q.size() == 0) begin
      fail("rom write arrived with no word sent");
      return;
    end
    exp = exp_q.pop_front();
    compare("rom_wr_addr", rom_wr_addr, next_addr);
    compare("rom_wr_data", rom_wr_data, exp);
    // signature slots at offsets 6..12 of the two title blocks
    if ((next_addr[23:4] == 20'h212 || next_addr[23:4] == 20'h1f2) &&
        next_addr[3:0] >= 4'd6 && next_addr[3:0] <= 4'd12) begin
      k = (next_addr[3:0] - 6) / 2;
      if (exp != POP_SIG_WORDS[k]) begin
        flags[next_addr[13]] = 1'b0;
      end
    end
    next_addr += 24'd2;
  endtask

  task automatic check_status(logic exp_pop);
    compare("rom_header", rom_header, next_addr[9]);
    compare("rom_size", rom_size, next_addr[23:12]);
    compare("rom_populous vs model", rom_populous, flags[next_addr[9]]);
    compare("rom_populous vs record", rom_populous, exp_pop);
  endtask

  task automatic check_drained();
    if (exp_q.size() != 0) begin
      fail($sformatf("%0d words never reached the memory controller", exp_q.size()));
    end
  endtask

  function automatic bit all_passed();
    return fail_cnt == 0 && err_total == 0 && pass_cnt > 0;
  endfunction

  task automatic summary();
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
  endtask

  // values seen at the edge are the ones the dut sampled
  always @(posedge clk_sys_42_95) begin
    if (rst_n) begin
      if (rom_wr_valid && ioctl_ready) begin
        fail("ioctl_ready high while a word is pending");
      end
      if (rom_wr_valid && rom_wr_ready) begin
        take_word();
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_pce_io.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_pce_io
  import pce_io_pkg::*;
();

  localparam int NUM_PADS = 4;
  localparam int TIMEOUT = 200;

  logic clk_sys_42_95;
  logic rst_n;
  pad_buttons_t [NUM_PADS-1:0] pads;
  logic pad_sel, pad_clr, multitap_en, six_button_en;
  pad_nibble_t pad_nibble;
  logic cart_download, ioctl_wr, swap_en, ioctl_ready;
  logic rom_wr_valid, rom_wr_ready;
  rom_word_t ioctl_data, rom_wr_data;
  rom_addr_t rom_wr_addr;
  logic rom_header, rom_populous;
  logic [11:0] rom_size;
  bram_byte_addr_t bram_addr;
  logic [7:0] bram_wdata, bram_rdata;
  logic bram_we;
  bram_word_addr_t save_addr;
  logic [15:0] save_wdata, save_rdata;
  logic save_we;
  logic [31:0] lcg_state = 32'h63eee65a;
  logic stall_en = 1'b0;
  logic stall_draw = 1'b1;
  // expected high_buttons of the tap
  logic hb = 1'b0;
  logic aborted = 1'b0;

  pce_io_top #(.NUM_PADS(NUM_PADS)) dut (.*);

  pce_io_checker #(.NUM_PADS(NUM_PADS)) chk (.*);

  initial begin
    clk_sys_42_95 = 1'b0;
    forever #20 clk_sys_42_95 = ~clk_sys_42_95;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // stall decision for the next rising edge
  always @(negedge clk_sys_42_95) begin
    if (stall_en) begin
      stall_draw = (lcg_next() >> 16) % 4 != 0;
    end
  end

  // memory controller stalls at random while a download runs
  always @(posedge clk_sys_42_95) begin
    rom_wr_ready <= stall_en ? stall_draw : 1'b1;
  end

  task automatic expire(string what);
    $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    aborted = 1'b1;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ioctl_ready && !aborted) begin
      @(posedge clk_sys_42_95);
      n++;
      if (n > TIMEOUT) expire("ioctl_ready going high");
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (rom_wr_valid && !aborted) begin
      @(posedge clk_sys_42_95);
      n++;
      if (n > TIMEOUT) expire("last rom write being taken");
    end
  endtask

  // title string in both blocks
  // 1f26 broken on purpose
  function automatic rom_word_t sig_word(rom_addr_t addr, rom_word_t w);
    if ((addr[23:4] == 20'h212 || addr[23:4] == 20'h1f2) &&
        addr[3:0] >= 4'd6 && addr[3:0] <= 4'd12) begin
      w = POP_SIG_WORDS[(addr[3:0] - 6) / 2];
    end
    if (addr == 24'h1f26) begin
      w = ~w;
    end
    return w;
  endfunction

  task automatic scan_pads(logic mt, logic six, int clears);
    logic [31:0] r;
    int port;
    port = 0;
    @(posedge clk_sys_42_95);
    for (int i = 0; i < NUM_PADS; i++) begin
      r = lcg_next();
      pads[i] <= r[11:0];
    end
    multitap_en <= mt;
    six_button_en <= six;
    pad_sel <= 1'b0;
    for (int i = 0; i < clears; i++) begin
      pad_clr <= 1'b1;
      @(posedge clk_sys_42_95);
      @(negedge clk_sys_42_95);
      chk.check_pad(0, 2'd0, 1'b1);
      @(posedge clk_sys_42_95);
      pad_clr <= 1'b0;
      hb = six ? ~hb : 1'b0;
      @(posedge clk_sys_42_95);
    end
    @(negedge clk_sys_42_95);
    chk.check_pad(port, {hb, 1'b0}, 1'b0);
    // eight select pulses walk the tap up to port 7
    for (int i = 0; i < 8; i++) begin
      @(posedge clk_sys_42_95);
      pad_sel <= 1'b1;
      @(posedge clk_sys_42_95);
      @(negedge clk_sys_42_95);
      chk.check_pad(port, {hb, 1'b1}, 1'b0);
      if (mt && port < 7) port++;
      @(posedge clk_sys_42_95);
      pad_sel <= 1'b0;
      @(posedge clk_sys_42_95);
      @(negedge clk_sys_42_95);
      chk.check_pad(port, {hb, 1'b0}, 1'b0);
    end
  endtask

  task automatic download(int words, logic swap, logic sig, logic exp_pop);
    logic [31:0] r;
    rom_word_t w;
    rom_addr_t addr;
    addr = '0;
    @(posedge clk_sys_42_95);
    swap_en <= swap;
    stall_en <= 1'b1;
    cart_download <= 1'b1;
    chk.start_download();
    @(posedge clk_sys_42_95);
    for (int i = 0; i < words && !aborted; i++) begin
      r = lcg_next();
      w = sig ? sig_word(addr, r[15:0]) : r[15:0];
      wait_ready();
      ioctl_wr <= 1'b1;
      ioctl_data <= w;
      chk.expect_word(w, swap);
      @(posedge clk_sys_42_95);
      ioctl_wr <= 1'b0;
      @(posedge clk_sys_42_95);
      addr += 24'd2;
    end
    wait_idle();
    stall_en <= 1'b0;
    cart_download <= 1'b0;
    repeat (2) @(posedge clk_sys_42_95);
    @(negedge clk_sys_42_95);
    chk.check_drained();
    chk.check_status(exp_pop);
  endtask

  task automatic core_read(bram_byte_addr_t a, logic [7:0] exp);
    @(posedge clk_sys_42_95);
    bram_addr <= a;
    bram_we <= 1'b0;
    @(posedge clk_sys_42_95);
    @(negedge clk_sys_42_95);
    chk.check_core_byte(a, exp);
  endtask

  // low byte lands at the even byte address
  task automatic save_write(bram_word_addr_t wa, logic [15:0] d);
    @(posedge clk_sys_42_95);
    save_addr <= wa;
    save_wdata <= d;
    save_we <= 1'b1;
    @(posedge clk_sys_42_95);
    save_we <= 1'b0;
    core_read({wa, 1'b0}, d[7:0]);
    core_read({wa, 1'b1}, d[15:8]);
  endtask

  task automatic core_write(bram_byte_addr_t a, logic [7:0] d, logic [15:0] exp_word);
    @(posedge clk_sys_42_95);
    bram_addr <= a;
    bram_wdata <= d;
    bram_we <= 1'b1;
    @(posedge clk_sys_42_95);
    bram_we <= 1'b0;
    save_addr <= a[10:1];
    @(posedge clk_sys_42_95);
    @(negedge clk_sys_42_95);
    chk.check_save_word(a[10:1], exp_word);
  endtask

  task automatic run_record(string op, logic [31:0] a, logic [31:0] b, logic [31:0] c);
    chk.begin_test($sformatf("%s %h %h %h", op, a, b, c));
    case (op)
      "pad": scan_pads(a[0], b[0], c);
      "load": download(a, b[0], 1'b0, c[0]);
      "pop": download(a >> 1, 1'b0, 1'b1, b[0]);
      "bhdr": core_read(a[10:0], b[7:0]);
      "bsw": save_write(a[9:0], b[15:0]);
      "bcw": core_write(a[10:0], b[7:0], c[15:0]);
      default: chk.fail($sformatf("unknown operation %s in the test file", op));
    endcase
    chk.end_test();
  endtask

  initial begin
    string line;
    string op;
    int fd;
    int code;
    logic [31:0] a, b, c;
    rst_n = 1'b0;
    pads = '0;
    pad_sel = 1'b0;
    pad_clr = 1'b0;
    multitap_en = 1'b0;
    six_button_en = 1'b0;
    cart_download = 1'b0;
    ioctl_wr = 1'b0;
    ioctl_data = '0;
    swap_en = 1'b0;
    rom_wr_ready = 1'b1;
    bram_addr = '0;
    bram_wdata = '0;
    bram_we = 1'b0;
    save_addr = '0;
    save_wdata = '0;
    save_we = 1'b0;
    repeat (5) @(posedge clk_sys_42_95);
    rst_n <= 1'b1;
    // let the header fill finish
    repeat (8) @(posedge clk_sys_42_95);
    fd = $fopen("dv/pce_io_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/pce_io_tests.txt");
      aborted = 1'b1;
    end
    while (fd != 0 && !aborted && !$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        a = '0;
        b = '0;
        c = '0;
        code = $sscanf(line, "%s %h %h %h", op, a, b, c);
        run_record(op, a, b, c);
      end
    end
    if (fd != 0) $fclose(fd);
    chk.summary();
    if (!aborted && chk.all_passed()) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/pce_io_tests.txt ====
# op arg1 arg2 arg3, all hex; pad: multitap_en six_button_en clears
# load: words swap_en populous, pop: end_addr populous, bhdr: byte_addr byte
# bsw: word_addr word, bcw: byte_addr byte save_word
bhdr 0 48
bhdr 1 55
bhdr 2 42
bhdr 3 4d
bhdr 4 00
bhdr 5 88
bhdr 6 10
bhdr 7 80
pad 1 0 1
pad 1 1 1
pad 1 1 1
pad 1 1 2
pad 1 0 1
pad 0 0 1
pad 0 1 1
pad 1 0 1
load 30 0 1
load 30 1 1
pop 1f30 1
pop 2130 0
bsw 10 a55a
bcw 21 3c 3c5a
bcw 20 c3 3cc3

// ==== vlog.f ====
src/pce_io_pkg.sv
src/pad_multitap.sv
src/cart_loader.sv
src/backup_ram.sv
src/pce_io_top.sv
dv/pce_io_checker.sv
dv/tb_pce_io.sv
